// File: common/rv_core_pkg.sv
package rv_core_pkg;

  // --------------------------------------------------------------------------
  // Widths and basic types
  // --------------------------------------------------------------------------

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [11:0]     csr_addr_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [2:0]      funct3_t;

  localparam word_t RESET_PC = '0;

  // Major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // Read-only Zicntr counters
  localparam csr_addr_t CSR_CYCLE   = 12'hc00;
  localparam csr_addr_t CSR_INSTRET = 12'hc02;

  localparam instr_t I_EBREAK = 32'h0010_0073;

  // ALU operation codes
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_AND    = 4'd2;
  localparam alu_op_t ALU_OR     = 4'd3;
  localparam alu_op_t ALU_XOR    = 4'd4;
  localparam alu_op_t ALU_SLL    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_SLT    = 4'd8;
  localparam alu_op_t ALU_SLTU   = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;

  // --------------------------------------------------------------------------
  // Sequencer state and decoded instruction
  // --------------------------------------------------------------------------

  typedef enum logic [1:0] {
    S_FETCH   = 2'd0,
    S_EXECUTE = 2'd1,
    S_MEMORY  = 2'd2,
    S_HALT    = 2'd3
  } state_e;

  typedef struct packed {
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    funct3_t   funct3;
    word_t     imm;
    alu_op_t   alu_op;
    logic      alu_a_pc;
    logic      alu_a_zero;
    logic      alu_b_imm;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      is_csr;
    logic      is_ebreak;
    logic      reg_write;
    csr_addr_t csr_addr;
  } decoded_t;

endpackage

// File: hw/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic                   clk,
  input  rv_core_pkg::reg_addr_t rs1_addr,
  input  rv_core_pkg::reg_addr_t rs2_addr,
  output rv_core_pkg::word_t     rs1_data,
  output rv_core_pkg::word_t     rs2_data,
  input  logic                   rd_en,
  input  rv_core_pkg::reg_addr_t rd_addr,
  input  rv_core_pkg::word_t     rd_data
);

  // x0 has no storage
  rv_core_pkg::word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (rd_en && (rd_addr != '0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
  input  rv_core_pkg::word_t   a,
  input  rv_core_pkg::word_t   b,
  input  rv_core_pkg::alu_op_t alu_op,
  input  rv_core_pkg::funct3_t funct3,
  output rv_core_pkg::word_t   result,
  output logic                 branch_taken
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign eq    = (a == b);
  assign lt_s  = ($signed(a) < $signed(b));
  assign lt_u  = (a < b);

  always_comb begin
    case (alu_op)
      rv_core_pkg::ALU_ADD:    result = a + b;
      rv_core_pkg::ALU_SUB:    result = a - b;
      rv_core_pkg::ALU_AND:    result = a & b;
      rv_core_pkg::ALU_OR:     result = a | b;
      rv_core_pkg::ALU_XOR:    result = a ^ b;
      rv_core_pkg::ALU_SLL:    result = a << shamt;
      rv_core_pkg::ALU_SRL:    result = a >> shamt;
      rv_core_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
      rv_core_pkg::ALU_SLT:    result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_s};
      rv_core_pkg::ALU_SLTU:   result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_u};
      default:                 result = b;
    endcase
  end

  // Branch condition on the two register operands
  always_comb begin
    case (funct3)
      3'b000:  branch_taken = eq;
      3'b001:  branch_taken = !eq;
      3'b100:  branch_taken = lt_s;
      3'b101:  branch_taken = !lt_s;
      3'b110:  branch_taken = lt_u;
      3'b111:  branch_taken = !lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
  input  rv_core_pkg::instr_t   instr,
  output rv_core_pkg::decoded_t decoded
);

  logic [6:0]           opcode;
  rv_core_pkg::word_t   imm_i;
  rv_core_pkg::word_t   imm_s;
  rv_core_pkg::word_t   imm_b;
  rv_core_pkg::word_t   imm_u;
  rv_core_pkg::word_t   imm_j;
  rv_core_pkg::alu_op_t alu_arith;
  logic                 is_sub;
  logic                 is_sra;

  assign opcode = instr[6:0];

  // --------------------------------------------------------------------------
  // Immediate formats
  // --------------------------------------------------------------------------

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // --------------------------------------------------------------------------
  // ALU code for OP and OP-IMM
  // --------------------------------------------------------------------------

  // No SUBI exists, but SRAI shares bit 30 with SRA
  assign is_sub = (opcode == rv_core_pkg::OPC_OP) & instr[30];
  assign is_sra = instr[30];

  always_comb begin
    case (instr[14:12])
      3'b000:  alu_arith = is_sub ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  alu_arith = rv_core_pkg::ALU_SLL;
      3'b010:  alu_arith = rv_core_pkg::ALU_SLT;
      3'b011:  alu_arith = rv_core_pkg::ALU_SLTU;
      3'b100:  alu_arith = rv_core_pkg::ALU_XOR;
      3'b101:  alu_arith = is_sra ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  alu_arith = rv_core_pkg::ALU_OR;
      default: alu_arith = rv_core_pkg::ALU_AND;
    endcase
  end

  // --------------------------------------------------------------------------
  // Class decode
  // --------------------------------------------------------------------------

  always_comb begin
    decoded          = '0;
    decoded.rd       = instr[11:7];
    decoded.rs1      = instr[19:15];
    decoded.rs2      = instr[24:20];
    decoded.funct3   = instr[14:12];
    decoded.csr_addr = instr[31:20];
    decoded.imm      = imm_i;
    decoded.alu_op   = rv_core_pkg::ALU_PASS_B;

    case (opcode)
      rv_core_pkg::OPC_LUI: begin
        decoded.imm        = imm_u;
        decoded.alu_op     = rv_core_pkg::ALU_ADD;
        decoded.alu_a_zero = 1'b1;
        decoded.alu_b_imm  = 1'b1;
        decoded.reg_write  = 1'b1;
      end
      rv_core_pkg::OPC_AUIPC: begin
        decoded.imm       = imm_u;
        decoded.alu_op    = rv_core_pkg::ALU_ADD;
        decoded.alu_a_pc  = 1'b1;
        decoded.alu_b_imm = 1'b1;
        decoded.reg_write = 1'b1;
      end
      rv_core_pkg::OPC_JAL: begin
        decoded.imm       = imm_j;
        decoded.is_jal    = 1'b1;
        decoded.reg_write = 1'b1;
      end
      rv_core_pkg::OPC_JALR: begin
        // ALU forms rs1 + imm for the target
        decoded.alu_op    = rv_core_pkg::ALU_ADD;
        decoded.alu_b_imm = 1'b1;
        decoded.is_jalr   = 1'b1;
        decoded.reg_write = 1'b1;
      end
      rv_core_pkg::OPC_BRANCH: begin
        decoded.imm       = imm_b;
        decoded.is_branch = 1'b1;
      end
      rv_core_pkg::OPC_LOAD: begin
        decoded.alu_op    = rv_core_pkg::ALU_ADD;
        decoded.alu_b_imm = 1'b1;
        decoded.is_load   = 1'b1;
        decoded.reg_write = 1'b1;
      end
      rv_core_pkg::OPC_STORE: begin
        decoded.imm       = imm_s;
        decoded.alu_op    = rv_core_pkg::ALU_ADD;
        decoded.alu_b_imm = 1'b1;
        decoded.is_store  = 1'b1;
      end
      rv_core_pkg::OPC_OP_IMM: begin
        decoded.alu_op    = alu_arith;
        decoded.alu_b_imm = 1'b1;
        decoded.reg_write = 1'b1;
      end
      rv_core_pkg::OPC_OP: begin
        decoded.alu_op    = alu_arith;
        decoded.reg_write = 1'b1;
      end
      rv_core_pkg::OPC_SYSTEM: begin
        if (instr == rv_core_pkg::I_EBREAK) begin
          decoded.is_ebreak = 1'b1;
        end else if (instr[14:12] == 3'b010) begin
          // Only the read side of CSRRS
          decoded.is_csr    = 1'b1;
          decoded.reg_write = 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// File: hw/rv_control.sv
`timescale 1ns/10ps

module rv_control (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_core_pkg::decoded_t decoded,
  input  logic                  branch_taken,
  output logic                  instr_load,
  output logic                  pc_write,
  output logic                  pc_take_target,
  output logic                  reg_write_en,
  output logic                  dmem_we,
  output logic                  retire,
  output logic                  halted
);

  rv_core_pkg::state_e state;
  rv_core_pkg::state_e state_next;

  logic is_mem;
  logic rd_nonzero;

  assign is_mem     = decoded.is_load | decoded.is_store;
  assign rd_nonzero = (decoded.rd != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_core_pkg::S_FETCH;
    end else begin
      state <= state_next;
    end
  end

  // Strobes follow the state with one instruction in flight
  always_comb begin
    state_next     = state;
    instr_load     = 1'b0;
    pc_write       = 1'b0;
    pc_take_target = 1'b0;
    reg_write_en   = 1'b0;
    dmem_we        = 1'b0;
    retire         = 1'b0;

    case (state)
      rv_core_pkg::S_FETCH: begin
        instr_load = 1'b1;
        state_next = rv_core_pkg::S_EXECUTE;
      end

      rv_core_pkg::S_EXECUTE: begin
        if (decoded.is_ebreak) begin
          retire     = 1'b1;
          state_next = rv_core_pkg::S_HALT;
        end else if (is_mem) begin
          state_next = rv_core_pkg::S_MEMORY;
        end else begin
          reg_write_en   = decoded.reg_write & rd_nonzero;
          pc_write       = 1'b1;
          pc_take_target = decoded.is_jal | decoded.is_jalr |
                           (decoded.is_branch & branch_taken);
          retire         = 1'b1;
          state_next     = rv_core_pkg::S_FETCH;
        end
      end

      rv_core_pkg::S_MEMORY: begin
        // Address is live for this cycle only
        dmem_we      = decoded.is_store;
        reg_write_en = decoded.is_load & decoded.reg_write & rd_nonzero;
        pc_write     = 1'b1;
        retire       = 1'b1;
        state_next   = rv_core_pkg::S_FETCH;
      end

      default: begin
        state_next = rv_core_pkg::S_HALT;
      end
    endcase
  end

  assign halted = (state == rv_core_pkg::S_HALT);

endmodule

// File: hw/rv_counters.sv
`timescale 1ns/10ps

module rv_counters (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   halted,
  input  logic                   retire,
  input  rv_core_pkg::csr_addr_t csr_addr,
  output rv_core_pkg::word_t     csr_rdata
);

  rv_core_pkg::word_t cycle;
  rv_core_pkg::word_t instret;

  // Both counters wrap at 32 bits
  always_ff @(posedge clk) begin
    if (reset) begin
      cycle   <= '0;
      instret <= '0;
    end else begin
      if (!halted) begin
        cycle <= cycle + 1'b1;
      end
      if (retire) begin
        instret <= instret + 1'b1;
      end
    end
  end

  // Unmapped addresses read as zero
  always_comb begin
    case (csr_addr)
      rv_core_pkg::CSR_CYCLE:   csr_rdata = cycle;
      rv_core_pkg::CSR_INSTRET: csr_rdata = instret;
      default:                  csr_rdata = '0;
    endcase
  end

endmodule

// File: hw/rv_datapath.sv
`timescale 1ns/10ps

module rv_datapath (
  input  logic                  clk,
  input  logic                  reset,
  input  rv_core_pkg::instr_t   imem_rdata,
  input  rv_core_pkg::decoded_t decoded,
  input  logic                  instr_load,
  input  logic                  pc_write,
  input  logic                  pc_take_target,
  input  logic                  reg_write_en,
  input  rv_core_pkg::word_t    csr_rdata,
  input  rv_core_pkg::word_t    dmem_rdata,
  output rv_core_pkg::word_t    pc,
  output rv_core_pkg::instr_t   instr,
  output rv_core_pkg::word_t    dmem_addr,
  output rv_core_pkg::word_t    dmem_wdata,
  output logic                  branch_taken
);

  rv_core_pkg::word_t pc_plus4;
  rv_core_pkg::word_t target_pc_rel;
  rv_core_pkg::word_t target_jalr;
  rv_core_pkg::word_t pc_next;
  rv_core_pkg::word_t rs1_data;
  rv_core_pkg::word_t rs2_data;
  rv_core_pkg::word_t alu_a;
  rv_core_pkg::word_t alu_b;
  rv_core_pkg::word_t alu_result;
  rv_core_pkg::word_t rd_data;

  // --------------------------------------------------------------------------
  // PC and instruction register
  // --------------------------------------------------------------------------

  assign pc_plus4      = pc + 32'd4;
  assign target_pc_rel = pc + decoded.imm;
  assign target_jalr   = {alu_result[rv_core_pkg::XLEN-1:1], 1'b0};

  assign pc_next = !pc_take_target ? pc_plus4 :
                   decoded.is_jalr ? target_jalr : target_pc_rel;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= rv_core_pkg::RESET_PC;
    end else if (pc_write) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_load) begin
      instr <= imem_rdata;
    end
  end

  // --------------------------------------------------------------------------
  // Register file and ALU
  // --------------------------------------------------------------------------

  rv_regfile regfile (
    .clk     (clk),
    .rs1_addr(decoded.rs1),
    .rs2_addr(decoded.rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .rd_en   (reg_write_en),
    .rd_addr (decoded.rd),
    .rd_data (rd_data)
  );

  assign alu_a = decoded.alu_a_zero ? '0 :
                 decoded.alu_a_pc   ? pc : rs1_data;
  assign alu_b = decoded.alu_b_imm ? decoded.imm : rs2_data;

  rv_alu alu (
    .a           (alu_a),
    .b           (alu_b),
    .alu_op      (decoded.alu_op),
    .funct3      (decoded.funct3),
    .result      (alu_result),
    .branch_taken(branch_taken)
  );

  // Loads and stores address through the ALU adder
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;

  // Writeback select
  always_comb begin
    if (decoded.is_load) begin
      rd_data = dmem_rdata;
    end else if (decoded.is_jal || decoded.is_jalr) begin
      rd_data = pc_plus4;
    end else if (decoded.is_csr) begin
      rd_data = csr_rdata;
    end else begin
      rd_data = alu_result;
    end
  end

endmodule

// File: hw/rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic                clk,
  input  logic                reset,
  output rv_core_pkg::word_t  imem_raddr,
  input  rv_core_pkg::instr_t imem_rdata,
  output rv_core_pkg::word_t  dmem_addr,
  input  rv_core_pkg::word_t  dmem_rdata,
  output logic                dmem_we,
  output rv_core_pkg::word_t  dmem_wdata,
  output logic                ebreak
);

  rv_core_pkg::instr_t   instr;
  rv_core_pkg::decoded_t decoded;
  rv_core_pkg::word_t    pc;
  rv_core_pkg::word_t    csr_rdata;

  logic branch_taken;
  logic instr_load;
  logic pc_write;
  logic pc_take_target;
  logic reg_write_en;
  logic retire;
  logic halted;

  // --------------------------------------------------------------------------
  // Sequencing
  // --------------------------------------------------------------------------

  rv_control control (
    .clk           (clk),
    .reset         (reset),
    .decoded       (decoded),
    .branch_taken  (branch_taken),
    .instr_load    (instr_load),
    .pc_write      (pc_write),
    .pc_take_target(pc_take_target),
    .reg_write_en  (reg_write_en),
    .dmem_we       (dmem_we),
    .retire        (retire),
    .halted        (halted)
  );

  rv_counters counters (
    .clk      (clk),
    .reset    (reset),
    .halted   (halted),
    .retire   (retire),
    .csr_addr (decoded.csr_addr),
    .csr_rdata(csr_rdata)
  );

  // --------------------------------------------------------------------------
  // Decode and datapath
  // --------------------------------------------------------------------------

  rv_decode decode (
    .instr  (instr),
    .decoded(decoded)
  );

  rv_datapath datapath (
    .clk           (clk),
    .reset         (reset),
    .imem_rdata    (imem_rdata),
    .decoded       (decoded),
    .instr_load    (instr_load),
    .pc_write      (pc_write),
    .pc_take_target(pc_take_target),
    .reg_write_en  (reg_write_en),
    .csr_rdata     (csr_rdata),
    .dmem_rdata    (dmem_rdata),
    .pc            (pc),
    .instr         (instr),
    .dmem_addr     (dmem_addr),
    .dmem_wdata    (dmem_wdata),
    .branch_taken  (branch_taken)
  );

  assign imem_raddr = pc;
  assign ebreak     = halted;

endmodule

// File: testbench/rv_core_checker.sv
`timescale 1ns/10ps

module rv_core_checker (
  input logic               clk,
  input logic               reset,
  input rv_core_pkg::word_t imem_raddr,
  input logic               dmem_we,
  input logic               ebreak
);

  // Read by the testbench at the end of the run
  int fail_count = 0;

  // Fetch addresses stay on word boundaries
  fetch_aligned: assert property (
    @(posedge clk) disable iff (reset) imem_raddr[1:0] == 2'b00
  ) else begin
    $error("imem_raddr is not word aligned");
    fail_count++;
  end

  // One write strobe per store
  single_write: assert property (
    @(posedge clk) disable iff (reset) dmem_we |=> !dmem_we
  ) else begin
    $error("dmem_we high for two cycles in a row");
    fail_count++;
  end

  halt_holds: assert property (
    @(posedge clk) disable iff (reset) ebreak |=> ebreak
  ) else begin
    $error("ebreak dropped without reset");
    fail_count++;
  end

  no_write_halted: assert property (
    @(posedge clk) disable iff (reset) ebreak |-> !dmem_we
  ) else begin
    $error("dmem_we raised while halted");
    fail_count++;
  end

endmodule

bind rv_core rv_core_checker checker_i (
  .clk       (clk),
  .reset     (reset),
  .imem_raddr(imem_raddr),
  .dmem_we   (dmem_we),
  .ebreak    (ebreak)
);

// File: testbench/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

  logic        clk;
  logic        reset;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_wdata;
  logic        ebreak;

  logic [31:0] imem [64];
  logic [31:0] dmem [64];
  logic [31:0] lfsr_state = 32'h852b;
  int          fill_idx;
  int          store_count;
  int          error_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  // Stimulus table with 12 program words per row in prog_flat
  string       test_name [$];
  logic [31:0] prog_flat [$];
  logic [31:0] res_addr [$];
  logic [31:0] exp_word [$];
  int          exp_stores [$];
  logic [31:0] cur [$];

  rv_core dut (
    .clk       (clk),
    .reset     (reset),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_addr (dmem_addr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_wdata(dmem_wdata),
    .ebreak    (ebreak)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Memory models
  // --------------------------------------------------------------------------

  assign imem_rdata = imem[imem_raddr[7:2]];
  assign dmem_rdata = dmem[dmem_addr[7:2]];

  // Data memory is refilled while reset is held
  always @(posedge clk) begin
    if (reset) begin
      for (fill_idx = 0; fill_idx < 64; fill_idx++) begin
        dmem[fill_idx] <= 32'h5a5a_0000 | (fill_idx << 2);
      end
    end else if (dmem_we) begin
      dmem[dmem_addr[7:2]] <= dmem_wdata;
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      store_count <= 0;
    end else if (dmem_we) begin
      store_count <= store_count + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: no ebreak within %0d cycles", cycle_limit);
      $display("Checks failed");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Instruction encoders and reference models
  // --------------------------------------------------------------------------

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  // Word store
  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // RV32I arithmetic where alt is instruction bit 30
  function automatic logic [31:0] alu_expect(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_expect(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // --------------------------------------------------------------------------
  // Table construction
  // --------------------------------------------------------------------------

  task automatic emit(logic [31:0] word);
    cur.push_back(word);
  endtask

  task automatic load_const(logic [4:0] rd, logic [31:0] value);
    logic [19:0] upper;
    upper = value[31:12] + {19'b0, value[11]};
    emit(enc_u(upper, rd, 7'b0110111));
    emit(enc_i(value[11:0], rd, 3'b000, rd, 7'b0010011));
  endtask

  // Closes a row with the result store and EBREAK
  task automatic add_row(string name, logic [4:0] result_reg, logic [31:0] addr,
                         logic [31:0] expected, int extra_stores);
    emit(enc_s(addr[11:0], result_reg, 5'd0));
    emit(32'h0010_0073);
    while (cur.size() < 12) begin
      cur.push_back(32'h0000_0013);
    end
    foreach (cur[i]) prog_flat.push_back(cur[i]);
    cur.delete();
    test_name.push_back(name);
    res_addr.push_back(addr);
    exp_word.push_back(expected);
    exp_stores.push_back(extra_stores + 1);
  endtask

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] v;
    logic [11:0] imm;
    logic [2:0]  f3;
    logic        alt;
    int          i;
    int          k;
    string       name;
    for (i = 0; i < 16; i++) begin
      f3  = i[3:1];
      alt = i[0];
      if (!alt || f3 == 3'd0 || f3 == 3'd5) begin
        a = rand_bits(32);
        b = rand_bits(32);
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(enc_r({1'b0, alt, 5'b0}, 5'd2, 5'd1, f3, 5'd3));
        add_row($sformatf("alu reg f3=%0d alt=%0d", f3, alt), 5'd3, 32'hf0,
                alu_expect(f3, alt, a, b), 0);
        // Bit 30 only matters for SRAI since there is no SUBI
        if (!(f3 == 3'd0 && alt)) begin
          a = rand_bits(32);
          v = rand_bits(12);
          imm = v[11:0];
          if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {1'b0, alt, 5'b0, imm[4:0]};
          end
          load_const(5'd1, a);
          emit(enc_i(imm, 5'd1, f3, 5'd3, 7'b0010011));
          add_row($sformatf("alu imm f3=%0d alt=%0d", f3, alt), 5'd3, 32'hf0,
                  alu_expect(f3, alt, a, {{20{imm[11]}}, imm}), 0);
        end
      end
    end

    // Signs differ so signed and unsigned compares disagree
    a = rand_bits(32) | 32'h8000_0000;
    b = rand_bits(32) & 32'h7fff_ffff;
    for (i = 0; i < 8; i++) begin
      f3 = i[2:0];
      if (f3 != 3'd2 && f3 != 3'd3) begin
        for (k = 0; k < 2; k++) begin
          x = (f3 <= 3'd1 || k == 0) ? a : b;
          y = (f3 <= 3'd1) ? ((k == 0) ? a : b) : ((k == 0) ? b : a);
          load_const(5'd1, x);
          load_const(5'd2, y);
          emit(enc_b(13'd12, 5'd2, 5'd1, f3));
          emit(enc_i(12'd1, 5'd0, 3'b000, 5'd5, 7'b0010011));
          emit(enc_j(21'd8, 5'd0));
          emit(enc_i(12'd2, 5'd0, 3'b000, 5'd5, 7'b0010011));
          add_row($sformatf("branch f3=%0d case %0d", f3, k), 5'd5, 32'hf0,
                  branch_expect(f3, x, y) ? 32'd2 : 32'd1, 0);
        end
      end
    end

    // JAL at 0x4 skips one word and links 0x8
    emit(enc_i(12'd0, 5'd0, 3'b000, 5'd5, 7'b0010011));
    emit(enc_j(21'd8, 5'd1));
    emit(enc_i(12'h40, 5'd1, 3'b000, 5'd1, 7'b0010011));
    emit(enc_i(12'h100, 5'd1, 3'b000, 5'd5, 7'b0010011));
    add_row("jal", 5'd5, 32'hf0, 32'h8 + 32'h100, 0);

    // JALR computes 17 and lands on 16
    emit(enc_i(12'd15, 5'd0, 3'b000, 5'd2, 7'b0010011));
    emit(enc_i(12'd2, 5'd2, 3'b000, 5'd1, 7'b1100111));
    emit(enc_i(12'h40, 5'd1, 3'b000, 5'd1, 7'b0010011));
    emit(enc_i(12'h40, 5'd1, 3'b000, 5'd1, 7'b0010011));
    emit(enc_i(12'h100, 5'd1, 3'b000, 5'd5, 7'b0010011));
    add_row("jalr", 5'd5, 32'hf0, 32'h8 + 32'h100, 0);

    v = rand_bits(32);
    load_const(5'd6, v);
    emit(enc_s(12'h40, 5'd6, 5'd0));
    emit(enc_i(12'h40, 5'd0, 3'b010, 5'd8, 7'b0000011));
    emit(enc_i(12'd1, 5'd8, 3'b000, 5'd8, 7'b0010011));
    add_row("load store", 5'd8, 32'h44, v + 32'd1, 1);

    // ADDI then SW then LW before the read take 2 + 3 + 3 cycles
    for (k = 0; k < 2; k++) begin
      if (k == 0) begin
        name = "instret";
      end else begin
        name = "cycle";
      end
      emit(enc_i(12'd3, 5'd0, 3'b000, 5'd1, 7'b0010011));
      emit(enc_s(12'h40, 5'd1, 5'd0));
      emit(enc_i(12'h40, 5'd0, 3'b010, 5'd2, 7'b0000011));
      emit(enc_i((k == 0) ? 12'hc02 : 12'hc00, 5'd0, 3'b010, 5'd3, 7'b1110011));
      add_row(name, 5'd3, 32'hf0,
              (k == 0) ? 32'd3 : 32'd2 + 32'd3 + 32'd3 + 32'd1, 1);
    end

    emit(enc_i(12'h055, 5'd0, 3'b000, 5'd0, 7'b0010011));
    emit(enc_u(20'h12345, 5'd0, 7'b0110111));
    emit(enc_i(12'd7, 5'd0, 3'b000, 5'd5, 7'b0010011));
    add_row("x0 stays zero", 5'd5, 32'hf0, 32'd7, 0);

    emit(32'h0000_0013);
    emit(enc_u(20'h12345, 5'd5, 7'b0010111));
    add_row("auipc", 5'd5, 32'hf0, 32'h1234_5004, 0);
  endtask

  // --------------------------------------------------------------------------
  // Checking and test sequence
  // --------------------------------------------------------------------------

  task automatic check(string signal, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("error at time %0t: %s is %h, expected %h", $time, signal, actual, expected);
    end
  endtask

  task automatic run_test(int t);
    int errors_before;
    int i;
    errors_before = error_count;
    @(posedge clk);
    reset <= 1'b1;
    // Unused words become ADDI x0 with the index as immediate
    for (i = 0; i < 64; i++) begin
      imem[i] = enc_i(i[11:0], 5'd0, 3'b000, 5'd0, 7'b0010011);
    end
    for (i = 0; i < 12; i++) begin
      imem[i] = prog_flat[t * 12 + i];
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    while (!ebreak) begin
      @(negedge clk);
    end
    for (i = 0; i < 20; i++) begin
      @(negedge clk);
      check("ebreak", {31'b0, ebreak}, 32'd1);
    end
    check("dmem result word", dmem[res_addr[t][7:2]], exp_word[t]);
    check("dmem_we pulse count", store_count, exp_stores[t]);
    $display("%s %s", (error_count == errors_before) ? "ok  " : "FAIL", test_name[t]);
  endtask

  initial begin
    int t;
    int failed_tests;
    int errors_before;
    reset = 1'b1;
    failed_tests = 0;
    build_table();
    cycle_limit = test_name.size() * (16 + 3 * 12 + 8);
    for (t = 0; t < test_name.size(); t++) begin
      errors_before = error_count;
      run_test(t);
      if (error_count != errors_before) begin
        failed_tests++;
      end
    end
    $display("Tests %0d, passed %0d, failed %0d, check errors %0d, assertion failures %0d",
             test_name.size(), test_name.size() - failed_tests, failed_tests, error_count,
             dut.checker_i.fail_count);
    if (error_count == 0 && dut.checker_i.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: rv_core.f
common/rv_core_pkg.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_decode.sv
hw/rv_control.sv
hw/rv_counters.sv
hw/rv_datapath.sv
hw/rv_core.sv
testbench/rv_core_checker.sv
testbench/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the rv_core testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_core_tb -Mdir obj_dir -f rv_core.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vrv_core_tb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
  exit 0
fi
exit 1
